/* project.f */
hdl/core_pkg.sv
hdl/bus_pkg.sv
hdl/mem_rd_if.sv
hdl/fetch_stream_if.sv
hdl/pc_gen.sv
hdl/fetch_unit.sv
hdl/skid_buffer.sv
hdl/fetch_top.sv
verif/fetch_checker.sv
verif/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the fetch stage testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 --top-module fetch_tb -f project.f -o fetch_sim \
  && ./obj_dir/fetch_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation failed"; exit 1; }

cat sim.log
grep -q "All tests passed!" sim.log \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }

/* verif/fetch_tb.sv */
// ------------------------------
// Memory model lives here. Fixed seed, run bounded by table length + 200
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam int NUM_ROWS = 12;

  typedef struct packed {
    int          cycles;    // Cycles to run
    int          duty;      // inst_ready high, percent
    bit          redir;     // Redirect at row start
    logic [31:0] target;
    int          min_insts; // Instructions owed by this row
  } row_t;

  logic                           clk = 1'b0;
  logic                           rst;
  logic                           redirect_valid;
  logic [core_pkg::XLEN-1:0]      redirect_pc;
  logic                           inst_ready;
  logic                           inst_valid;
  logic [core_pkg::XLEN-1:0]      inst_pc;
  logic [core_pkg::XLEN-1:0]      inst_word;
  logic                           inst_fault;
  logic                           mem_arvalid;
  logic [bus_pkg::ADDR_WIDTH-1:0] mem_araddr;
  logic                           mem_rready;
  logic                           mem_arready = 1'b0;
  logic                           mem_rvalid  = 1'b0;
  logic [bus_pkg::BLOCK_BITS-1:0] mem_rdata   = '0;
  logic [1:0]                     mem_rresp   = 2'b00;
  logic [bus_pkg::ADDR_WIDTH-1:0] blk_addr    = '0;
  logic                           rd_busy     = 1'b0;
  int ar_wait = 0;
  int r_wait  = 0;

  row_t rows [NUM_ROWS];
  int expected_total = 0;
  int cycle_limit    = 0;
  int cycle          = 0;
  int error_count;
  int inst_count;

  always #10 clk = ~clk;

  fetch_top u_dut (
    .clk (clk), .rst (rst),
    .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
    .mem_arvalid (mem_arvalid), .mem_arready (mem_arready), .mem_araddr (mem_araddr),
    .mem_rvalid (mem_rvalid), .mem_rready (mem_rready),
    .mem_rdata (mem_rdata), .mem_rresp (mem_rresp),
    .inst_valid (inst_valid), .inst_ready (inst_ready),
    .inst_pc (inst_pc), .inst_word (inst_word), .inst_fault (inst_fault)
  );

  fetch_checker u_checker (
    .clk (clk), .rst (rst),
    .redirect_valid (redirect_valid), .redirect_pc (redirect_pc),
    .mem_arvalid (mem_arvalid), .mem_arready (mem_arready),
    .mem_araddr (mem_araddr), .mem_rready (mem_rready),
    .inst_valid (inst_valid), .inst_ready (inst_ready),
    .inst_pc (inst_pc), .inst_word (inst_word), .inst_fault (inst_fault),
    .fetch_state (u_dut.u_fetch_unit.state_q),
    .error_count (error_count), .inst_count (inst_count)
  );

  function automatic logic [bus_pkg::BLOCK_BITS-1:0] block_data(input logic [31:0] addr);
    logic [bus_pkg::BLOCK_BITS-1:0] blk;
    for (int k = 0; k < bus_pkg::BLOCK_WORDS; k++) begin
      blk[32*k +: 32] = (addr + 32'(4 * k)) ^ 32'hA5A5_0000;
    end
    return blk;
  endfunction

  // AR accepted after 0-3 cycles, R returned 1-5 cycles later
  always @(posedge clk) begin : mem_responder
    int unsigned pick;
    if (rst) begin
      mem_arready <= 1'b0;
      mem_rvalid  <= 1'b0;
      rd_busy     <= 1'b0;
      ar_wait     <= 0;
    end else if (!rd_busy) begin
      if (mem_arvalid && mem_arready) begin
        mem_arready <= 1'b0;
        blk_addr    <= mem_araddr;
        r_wait      <= 1 + $urandom % 5;
        rd_busy     <= 1'b1;
      end else if (mem_arvalid) begin
        if (ar_wait <= 1) mem_arready <= 1'b1;
        if (ar_wait > 0) ar_wait <= ar_wait - 1;
      end
    end else if (mem_rvalid) begin
      if (mem_rready) begin
        mem_rvalid  <= 1'b0;
        rd_busy     <= 1'b0;
        pick = $urandom % 4;
        ar_wait     <= pick;
        mem_arready <= (pick == 0); // Zero wait, ready ahead of arvalid
      end
    end else if (r_wait <= 1) begin
      mem_rvalid <= 1'b1;
      mem_rdata  <= block_data(blk_addr);
      mem_rresp  <= (blk_addr >= 32'h2000 && blk_addr <= 32'h20FF) ? bus_pkg::SLVERR
                                                                   : bus_pkg::OKAY;
    end else begin
      r_wait <= r_wait - 1;
    end
  end

  task automatic load_table();
    rows[0]  = '{80, 100, 1'b0, 32'h0000_0000, 6};  // Straight run from reset
    rows[1]  = '{80, 50,  1'b0, 32'h0000_0000, 4};
    rows[2]  = '{60, 100, 1'b1, 32'h0000_2000, 4};  // Faulting region
    rows[3]  = '{60, 30,  1'b0, 32'h0000_0000, 2};
    rows[4]  = '{50, 100, 1'b1, 32'h0000_20F8, 4};  // Leaves the fault region
    rows[5]  = '{60, 0,   1'b0, 32'h0000_0000, 0};  // Full stall
    rows[6]  = '{60, 100, 1'b0, 32'h0000_0000, 4};
    rows[7]  = '{40, 100, 1'b1, 32'h0000_3004, 3};  // Mid-block target
    rows[8]  = '{40, 70,  1'b1, 32'h0000_4008, 2};
    rows[9]  = '{30, 0,   1'b1, 32'h0000_5000, 0};  // Redirect under stall
    rows[10] = '{60, 100, 1'b0, 32'h0000_0000, 4};
    rows[11] = '{80, 60,  1'b1, 32'h0000_2080, 4};
  endtask

  task automatic finish_run(input int run_errors);
    $display("Closing: %0d checker errors, %0d run errors, %0d instructions checked",
             error_count, run_errors, inst_count);
    if (error_count + run_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions delivered",
               cycle, inst_count, expected_total);
      finish_run(1);
    end
  end

  initial begin
    void'($urandom(32022));
    rst            = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    inst_ready     = 1'b0;
    load_table();
    for (int r = 0; r < NUM_ROWS; r++) begin
      expected_total += rows[r].min_insts;
      cycle_limit    += rows[r].cycles;
    end
    cycle_limit += 200;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (rows[r].redir) begin
        redirect_valid <= 1'b1;
        redirect_pc    <= rows[r].target;
      end
      for (int c = 0; c < rows[r].cycles; c++) begin
        inst_ready <= (($urandom % 100) < rows[r].duty);
        @(posedge clk);
        redirect_valid <= 1'b0; // One-cycle pulse
      end
    end
    inst_ready <= 1'b1; // Drain until the owed count shows up
    while (inst_count < expected_total) @(posedge clk);
    finish_run(0);
  end

endmodule

`default_nettype wire

/* verif/fetch_checker.sv */
// ------------------------------
// Watches top ports only. PC order restarts at reset and on each redirect
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_checker (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           redirect_valid,
  input  logic [core_pkg::XLEN-1:0]      redirect_pc,
  input  logic                           mem_arvalid,
  input  logic                           mem_arready,
  input  logic [bus_pkg::ADDR_WIDTH-1:0] mem_araddr,
  input  logic                           mem_rready,
  input  logic                           inst_valid,
  input  logic                           inst_ready,
  input  logic [core_pkg::XLEN-1:0]      inst_pc,
  input  logic [core_pkg::XLEN-1:0]      inst_word,
  input  logic                           inst_fault,
  input  core_pkg::fetch_state_e         fetch_state,
  output int                             error_count,
  output int                             inst_count
);

  logic [core_pkg::XLEN-1:0] exp_pc;
  int ar_pending;  // Reads issued since the last output transfer
  int since_rst;   // Cycles since reset release
  int errors = 0;
  int count  = 0;

  assign error_count = errors;
  assign inst_count  = count;

  // Memory rule: word k of a block is block address + 4k, XOR A5A5_0000
  function automatic logic [core_pkg::XLEN-1:0] expected_word(input logic [31:0] pc);
    return ({pc[31:4], 4'b0000} + {28'd0, pc[3:2], 2'b00}) ^ 32'hA5A5_0000;
  endfunction

  function automatic logic expected_fault(input logic [31:0] pc);
    return (pc >= 32'h0000_2000) && (pc <= 32'h0000_20FF); // SLVERR region
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp_v, act_v);
      errors++;
    end
  endtask

  always @(posedge clk) begin : watch
    logic [core_pkg::XLEN-1:0] pc_next;
    int                        ar_next;
    if (rst) begin
      exp_pc     <= core_pkg::RESET_VECTOR;
      ar_pending <= 0;
      since_rst  <= 0;
      if (inst_valid || mem_arvalid || mem_rready) begin
        $display("Error at %0d ns: inst_valid, mem_arvalid or mem_rready high during reset",
                 $time);
        errors++;
      end
    end else begin
      pc_next = exp_pc;
      ar_next = ar_pending;
      if (since_rst < 8) since_rst <= since_rst + 1;
      if ((since_rst < 1 && mem_arvalid) || (since_rst < 4 && inst_valid)) begin
        $display("Error at %0d ns: output or read active too early after reset", $time);
        errors++;
      end
      // Block reads are aligned to 16 bytes
      if (mem_arvalid) begin
        compare_value("mem_araddr", {mem_araddr[31:4], 4'b0000}, mem_araddr);
      end
      // Two skid entries plus the fetch unit hold three fetches at most
      if (ar_pending >= 3 && mem_arvalid) begin
        $display("Error at %0d ns: read issued with three fetches stalled, fetch state %s",
                 $time, fetch_state.name());
        errors++;
      end
      if (mem_arvalid && mem_arready) ar_next = ar_next + 1;
      if (inst_valid && inst_ready) begin
        compare_value("inst_pc", exp_pc, inst_pc);
        compare_value("inst_word", expected_word(exp_pc), inst_word);
        compare_value("inst_fault", {31'd0, expected_fault(exp_pc)}, {31'd0, inst_fault});
        count++;
        pc_next = exp_pc + core_pkg::INST_BYTES;
        ar_next = (mem_arvalid && mem_arready) ? 1 : 0;
      end
      if (redirect_valid) begin
        pc_next = redirect_pc;
        // A cancelled fetch may still owe its AR
        ar_next = (mem_arvalid && !mem_arready) ? -1 : 0;
      end
      exp_pc     <= pc_next;
      ar_pending <= ar_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
// ------------------------------
// Memory sits outside on mem_* ports. First inst_valid 4+ cycles after reset
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           redirect_valid,
  input  logic [core_pkg::XLEN-1:0]      redirect_pc,
  output logic                           mem_arvalid,
  input  logic                           mem_arready,
  output logic [bus_pkg::ADDR_WIDTH-1:0] mem_araddr,
  input  logic                           mem_rvalid,
  output logic                           mem_rready,
  input  logic [bus_pkg::BLOCK_BITS-1:0] mem_rdata,
  input  logic [1:0]                     mem_rresp,
  output logic                           inst_valid,
  input  logic                           inst_ready,
  output logic [core_pkg::XLEN-1:0]      inst_pc,
  output logic [core_pkg::XLEN-1:0]      inst_word,
  output logic                           inst_fault
);

  logic                      next_pc_valid;
  logic                      next_pc_ready;
  logic [core_pkg::XLEN-1:0] next_pc;
  logic                      flush;
  core_pkg::fetch_pkt_t      out_pkt;

  mem_rd_if       mem_if ();
  fetch_stream_if stream_if ();

  // Subordinate side of the read channel goes off chip
  assign mem_arvalid      = mem_if.arvalid;
  assign mem_araddr       = mem_if.araddr;
  assign mem_rready       = mem_if.rready;
  assign mem_if.arready   = mem_arready;
  assign mem_if.rvalid    = mem_rvalid;
  assign mem_if.rdata     = mem_rdata;
  assign mem_if.rresp     = bus_pkg::resp_e'(mem_rresp);

  pc_gen u_pc_gen (
    .clk            (clk),
    .rst            (rst),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .next_pc_valid  (next_pc_valid),
    .next_pc        (next_pc),
    .next_pc_ready  (next_pc_ready),
    .flush          (flush)
  );

  fetch_unit u_fetch_unit (
    .clk            (clk),
    .rst            (rst),
    .next_pc_valid  (next_pc_valid),
    .next_pc        (next_pc),
    .next_pc_ready  (next_pc_ready),
    .flush          (flush),
    .mem            (mem_if),
    .out            (stream_if)
  );

  skid_buffer u_skid_buffer (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .in        (stream_if),
    .out_valid (inst_valid),
    .out_pkt   (out_pkt),
    .out_ready (inst_ready)
  );

  assign inst_pc    = out_pkt.pc;
  assign inst_word  = out_pkt.inst;
  assign inst_fault = out_pkt.fault;

endmodule

`default_nettype wire

/* hdl/skid_buffer.sv */
// ------------------------------
// Two entries, in order. Input ready is registered state only
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module skid_buffer (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  fetch_stream_if.sink         in,
  output logic                 out_valid,
  output core_pkg::fetch_pkt_t out_pkt,
  input  logic                 out_ready
);

  // Main entry drives the output, skid catches the overflow
  logic                 main_valid;
  logic                 skid_valid;
  core_pkg::fetch_pkt_t main_pkt;
  core_pkg::fetch_pkt_t skid_pkt;

  logic in_xfer;
  logic out_xfer;
  logic main_free;

  // Skid full implies main full, so this is "fewer than two"
  assign in.ready = !skid_valid;

  assign out_valid = main_valid;
  assign out_pkt   = main_pkt;

  assign in_xfer   = in.valid && in.ready;
  assign out_xfer  = main_valid && out_ready;
  assign main_free = !main_valid || out_xfer; // Main can take new data this edge

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_free) begin
      main_valid <= skid_valid || in_xfer;
      skid_valid <= 1'b0; // Skid moves up, no input while it is full
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (main_free) begin
      if (skid_valid) begin
        main_pkt <= skid_pkt; // Older item first
      end else if (in_xfer) begin
        main_pkt <= in.pkt;
      end
    end else if (in_xfer) begin
      skid_pkt <= in.pkt;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_unit.sv */
// ------------------------------
// One fetch outstanding at a time. No cache, every PC reads its block from memory
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      next_pc_valid,
  input  logic [core_pkg::XLEN-1:0] next_pc,
  output logic                      next_pc_ready,
  input  logic                      flush,
  mem_rd_if.manager                 mem,
  fetch_stream_if.source            out
);

  core_pkg::fetch_state_e state_q;

  logic arvalid_q;
  logic rready_q;

  // Payload of the current fetch
  logic [core_pkg::XLEN-1:0] pc_q;
  logic [core_pkg::XLEN-1:0] inst_q;
  logic                      fault_q;

  logic pc_xfer;
  logic ar_xfer;
  logic r_xfer;
  logic rsp_fault;

  logic [bus_pkg::OFFSET_BITS-1:0]                       word_idx;
  logic [bus_pkg::BLOCK_WORDS-1:0][core_pkg::XLEN-1:0]   block_words;

  assign next_pc_ready = (state_q == core_pkg::IDLE);

  assign pc_xfer = next_pc_valid && next_pc_ready;
  assign ar_xfer = arvalid_q && mem.arready;
  assign r_xfer  = rready_q && mem.rvalid;

  // Block address, low offset bits cleared
  assign mem.arvalid = arvalid_q;
  assign mem.araddr  = {pc_q[bus_pkg::ADDR_WIDTH-1:bus_pkg::OFFSET_LSB+bus_pkg::OFFSET_BITS],
                        {(bus_pkg::OFFSET_LSB + bus_pkg::OFFSET_BITS){1'b0}}};
  assign mem.rready  = rready_q;

  // Word select out of the returned block
  assign word_idx    = pc_q[bus_pkg::OFFSET_LSB +: bus_pkg::OFFSET_BITS];
  assign block_words = mem.rdata;
  assign rsp_fault   = (mem.rresp == bus_pkg::SLVERR) || (mem.rresp == bus_pkg::DECERR);

  assign out.valid = (state_q == core_pkg::HOLD);
  assign out.pkt   = '{pc: pc_q, inst: inst_q, fault: fault_q};

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= core_pkg::IDLE;
      arvalid_q <= 1'b0;
      rready_q  <= 1'b0;
    end else begin
      // Bus handshakes run the same way in LOAD and DRAIN
      if (pc_xfer) begin
        arvalid_q <= 1'b1;
      end
      if (ar_xfer) begin
        arvalid_q <= 1'b0;
        rready_q  <= 1'b1; // R may only follow the AR
      end
      if (r_xfer) begin
        rready_q <= 1'b0;
      end

      case (state_q)
        core_pkg::IDLE: begin
          if (pc_xfer) begin
            state_q <= core_pkg::LOAD;
          end
        end
        core_pkg::LOAD: begin
          if (r_xfer) begin
            // Data arriving with the flush is simply dropped
            state_q <= flush ? core_pkg::IDLE : core_pkg::HOLD;
          end else if (flush) begin
            state_q <= core_pkg::DRAIN;
          end
        end
        core_pkg::DRAIN: begin
          if (r_xfer) begin
            state_q <= core_pkg::IDLE;
          end
        end
        core_pkg::HOLD: begin
          if (flush || out.ready) begin
            state_q <= core_pkg::IDLE;
          end
        end
        default: begin
          state_q <= core_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pc_xfer) begin
      pc_q <= next_pc;
    end
    if (r_xfer && (state_q == core_pkg::LOAD)) begin
      inst_q  <= block_words[word_idx];
      fault_q <= rsp_fault;
    end
  end

endmodule

`default_nettype wire

/* hdl/pc_gen.sv */
// ------------------------------
// Sequential PC only, no prediction. A redirect is always accepted
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     redirect_valid,
  input  logic [core_pkg::XLEN-1:0] redirect_pc,
  output logic                     next_pc_valid,
  output logic [core_pkg::XLEN-1:0] next_pc,
  input  logic                     next_pc_ready,
  output logic                     flush
);

  logic [core_pkg::XLEN-1:0] pc_q;
  logic                      pc_xfer;

  // There is always a next address, except while a redirect replaces it
  assign next_pc_valid = !redirect_valid;
  assign next_pc       = pc_q;
  assign pc_xfer       = next_pc_valid && next_pc_ready;

  // Redirect cancels everything in flight this cycle
  assign flush = redirect_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= core_pkg::RESET_VECTOR;
    end else if (redirect_valid) begin
      pc_q <= redirect_pc; // Wins over the increment
    end else if (pc_xfer) begin
      pc_q <= pc_q + core_pkg::INST_BYTES;
    end
  end

endmodule

`default_nettype wire

/* hdl/fetch_stream_if.sv */
// ------------------------------
// Valid/ready stream of fetched instructions
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface fetch_stream_if;

  logic                 valid;
  logic                 ready;
  core_pkg::fetch_pkt_t pkt;

  modport source (output valid, pkt, input ready);

  modport sink (input valid, pkt, output ready);

endinterface

`default_nettype wire

/* hdl/mem_rd_if.sv */
// ------------------------------
// AR and R channels only, one outstanding read
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if;

  // Address channel
  logic                            arvalid;
  logic                            arready;
  logic [bus_pkg::ADDR_WIDTH-1:0]  araddr;  // Block aligned

  // Read data channel
  logic                            rvalid;
  logic                            rready;
  logic [bus_pkg::BLOCK_BITS-1:0]  rdata;
  bus_pkg::resp_e                  rresp;

  modport manager (
    output arvalid, araddr, rready,
    input  arready, rvalid, rdata, rresp
  );

  modport subordinate (
    input  arvalid, araddr, rready,
    output arready, rvalid, rdata, rresp
  );

endinterface

`default_nettype wire

/* hdl/bus_pkg.sv */
// ------------------------------
// Read channel of the memory bus. One 128-bit block per request, no bursts
// ------------------------------
`default_nettype none

package bus_pkg;

  localparam int ADDR_WIDTH  = 32;
  localparam int BLOCK_BITS  = 128; // rdata width
  localparam int BLOCK_WORDS = 4;   // Instructions per block

  // Word index inside a block sits at address bits 3:2
  localparam int OFFSET_LSB  = 2;
  localparam int OFFSET_BITS = 2;

  // Response codes, SLVERR and DECERR count as faults
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

endpackage

`default_nettype wire

/* hdl/core_pkg.sv */
// ------------------------------
// RV32 fetch path constants. No compressed instructions, one fault bit per packet
// ------------------------------
`default_nettype none

package core_pkg;

  localparam int XLEN = 32;

  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h0000_1000; // First fetch after reset
  localparam logic [XLEN-1:0] INST_BYTES   = 32'd4;         // Sequential PC step

  // One fetched instruction on its way to decode
  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
    logic            fault; // Bus error on this fetch
  } fetch_pkt_t;

  // Fetch unit FSM states
  typedef enum logic [1:0] {
    IDLE,  // Ready for a new PC
    LOAD,  // AR/R handshakes in progress
    DRAIN, // Cancelled fetch, response still owed
    HOLD   // Packet waiting for the skid buffer
  } fetch_state_e;

endpackage

`default_nettype wire
